// File: source/rv_core_cfg.svh
/* Width, reset address and alignment macros for the RV32I combinational core */

`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Register file address width
`define RV_REG_AW 5

// PC value after reset
`define RV_PROGADDR_RESET 32'h0000_0000

// Jump targets keep even addresses only
`define RV_ALIGN_MASK 32'hFFFF_FFFE

`endif

// File: source/rv_core_pkg.sv
/* Opcode enum, instruction word union and operation class enum */

package rv_core_pkg;

	// RV32I major opcodes, low two bits included
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} insn_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} insn_i_t;

	// Same word seen as R-type and as I-type
	typedef union packed {
		insn_r_t r;
		insn_i_t i;
	} insn_u;

	typedef enum logic [2:0] {
		cls_alu, cls_lui, cls_auipc, cls_jump, cls_jumpr, cls_branch, cls_load, cls_store
	} op_class_e;

endpackage

// File: source/rv_stage_if.sv
/* Decoded instruction and operand bundle between decode, execute and memory stages */

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

interface rv_stage_if;
	import rv_core_pkg::*;

	op_class_e           op_class; // What the instruction does
	logic [2:0]          funct3;
	logic                alt;      // SUB or SRA
	logic                imm_op;   // Operand b is the immediate
	logic [`RV_XLEN-1:0] imm;
	logic [`RV_XLEN-1:0] rs1_val;  // Zero for x0
	logic [`RV_XLEN-1:0] rs2_val;
	logic [`RV_XLEN-1:0] pc;

	modport decode (
		output op_class, funct3, alt, imm_op, imm, rs1_val, rs2_val, pc
	);

	modport exec (
		input op_class, funct3, alt, imm_op, imm, rs1_val, rs2_val, pc
	);

	modport mem (
		input op_class, funct3, rs2_val
	);

endinterface

// File: source/rv_decode.sv
/* Decode stage with field extraction, immediates, register requests
   and illegal encoding detection */

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_decode (
	input  rv_core_pkg::insn_u    insn,
	input  logic                  insn_valid,
	input  logic [`RV_XLEN-1:0]   insn_addr,
	input  logic [`RV_XLEN-1:0]   rs1_rdata,
	input  logic [`RV_XLEN-1:0]   rs2_rdata,
	output logic [`RV_REG_AW-1:0] rs1_addr,
	output logic [`RV_REG_AW-1:0] rs2_addr,
	output logic [`RV_REG_AW-1:0] rd_addr,
	output logic                  rs1_request,
	output logic                  rs2_request,
	output logic                  rd_request,
	output logic                  illegal,
	rv_stage_if.decode            stage
);
	import rv_core_pkg::*;

	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;
	logic [6:0]          funct7;
	logic [2:0]          funct3;
	op_class_e           op_class;
	logic                use_rs1;
	logic                use_rs2;
	logic                use_rd;
	logic                use_imm;
	logic                legal;
	logic                valid_insn;

	assign funct7 = insn.r.funct7;
	assign funct3 = insn.r.funct3;

	assign imm_i = {{20{insn[31]}}, insn.i.imm12};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	always_comb begin
		op_class = cls_alu;
		use_rs1  = 1'b0;
		use_rs2  = 1'b0;
		use_rd   = 1'b0;
		use_imm  = 1'b0;
		legal    = 1'b0;
		case (insn.r.opcode)
			opc_lui: begin
				op_class = cls_lui;
				use_rd   = 1'b1;
				legal    = 1'b1;
			end
			opc_auipc: begin
				op_class = cls_auipc;
				use_rd   = 1'b1;
				legal    = 1'b1;
			end
			opc_jal: begin
				op_class = cls_jump;
				use_rd   = 1'b1;
				legal    = 1'b1;
			end
			opc_jalr: begin
				op_class = cls_jumpr;
				use_rs1  = 1'b1;
				use_rd   = 1'b1;
				use_imm  = 1'b1;
				legal    = (funct3 == 3'b000);
			end
			opc_branch: begin
				op_class = cls_branch;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
				legal    = (funct3[2:1] != 2'b01); // 010 and 011 unused
			end
			opc_load: begin
				op_class = cls_load;
				use_rs1  = 1'b1;
				use_rd   = 1'b1;
				use_imm  = 1'b1;
				legal    = (funct3[1:0] != 2'b11) && (funct3 != 3'b110);
			end
			opc_store: begin
				op_class = cls_store;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
				use_imm  = 1'b1;
				legal    = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
			end
			opc_op_imm: begin
				use_rs1 = 1'b1;
				use_rd  = 1'b1;
				use_imm = 1'b1;
				case (funct3)
					3'b001:  legal = (funct7 == 7'b0000000); // SLLI
					3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					default: legal = 1'b1;
				endcase
			end
			opc_op: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rd  = 1'b1;
				legal   = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
			end
			default: legal = 1'b0;
		endcase
	end

	assign illegal    = !legal;
	assign valid_insn = insn_valid && legal;

	assign rs1_addr = use_rs1 ? insn.r.rs1 : '0;
	assign rs2_addr = use_rs2 ? insn.r.rs2 : '0;
	assign rd_addr  = use_rd ? insn.r.rd : '0;

	// x0 is never requested
	assign rs1_request = valid_insn && (rs1_addr != '0);
	assign rs2_request = valid_insn && (rs2_addr != '0);
	assign rd_request  = valid_insn && (rd_addr != '0);

	// Invalid or illegal words fall back to a plain ALU op with no side effects
	assign stage.op_class = valid_insn ? op_class : cls_alu;
	assign stage.funct3   = funct3;
	assign stage.alt      = funct7[5] && ((insn.r.opcode == opc_op) || (funct3 == 3'b101));
	assign stage.imm_op   = use_imm;
	assign stage.imm      = (op_class == cls_lui || op_class == cls_auipc) ? imm_u :
		(op_class == cls_jump)   ? imm_j :
		(op_class == cls_branch) ? imm_b :
		(op_class == cls_store)  ? imm_s : imm_i;
	assign stage.rs1_val  = (rs1_addr == '0) ? '0 : rs1_rdata;
	assign stage.rs2_val  = (rs2_addr == '0) ? '0 : rs2_rdata;
	assign stage.pc       = insn_addr;

endmodule

// File: source/rv_execute.sv
/* Execute stage with the ALU, branch compare and next PC selection */

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_execute (
	rv_stage_if.exec            stage,
	output logic [`RV_XLEN-1:0] alu_res,
	output logic [`RV_XLEN-1:0] pc_next
);
	import rv_core_pkg::*;

	logic [`RV_XLEN-1:0] opb;
	logic [`RV_XLEN-1:0] sum;
	logic [`RV_XLEN-1:0] diff;
	logic [`RV_XLEN-1:0] alu_val;
	logic [`RV_XLEN-1:0] pc_plus4;
	logic [`RV_XLEN-1:0] pc_target;
	logic [4:0]          shamt;
	logic                lt;
	logic                ltu;
	logic                eq;
	logic                cmp;
	logic                taken;

	assign opb   = stage.imm_op ? stage.imm : stage.rs2_val;
	assign shamt = opb[4:0];

	assign sum  = stage.rs1_val + opb; // Also the load/store address
	assign diff = stage.rs1_val - opb;
	assign eq   = (stage.rs1_val == opb);
	assign lt   = ($signed(stage.rs1_val) < $signed(opb));
	assign ltu  = (stage.rs1_val < opb);

	always_comb begin
		case (stage.funct3)
			3'b000:  alu_val = stage.alt ? diff : sum;
			3'b001:  alu_val = stage.rs1_val << shamt;
			3'b010:  alu_val = {{(`RV_XLEN-1){1'b0}}, lt};
			3'b011:  alu_val = {{(`RV_XLEN-1){1'b0}}, ltu};
			3'b100:  alu_val = stage.rs1_val ^ opb;
			3'b101:  alu_val = stage.alt ? $unsigned($signed(stage.rs1_val) >>> shamt) :
				stage.rs1_val >> shamt;
			3'b110:  alu_val = stage.rs1_val | opb;
			default: alu_val = stage.rs1_val & opb;
		endcase
	end

	assign pc_plus4  = stage.pc + `RV_XLEN'd4;
	assign pc_target = stage.pc + stage.imm;

	// funct3[2:1] picks the compare, funct3[0] inverts it
	always_comb begin
		case (stage.funct3[2:1])
			2'b00:   cmp = eq;
			2'b10:   cmp = lt;
			2'b11:   cmp = ltu;
			default: cmp = 1'b0;
		endcase
	end

	assign taken = cmp ^ stage.funct3[0];

	always_comb begin
		case (stage.op_class)
			cls_alu:   alu_res = alu_val;
			cls_lui:   alu_res = stage.imm;
			cls_auipc: alu_res = pc_target;
			cls_jump:  alu_res = pc_plus4; // Link value
			cls_jumpr: alu_res = pc_plus4;
			default:   alu_res = sum;
		endcase
	end

	always_comb begin
		case (stage.op_class)
			cls_jump:   pc_next = pc_target & `RV_ALIGN_MASK;
			cls_jumpr:  pc_next = sum & `RV_ALIGN_MASK;
			cls_branch: pc_next = taken ? (pc_target & `RV_ALIGN_MASK) : pc_plus4;
			default:    pc_next = pc_plus4;
		endcase
	end

endmodule

// File: source/rv_mem_stage.sv
/* Memory and write-back stage with request forming, load extension
   and write-back select */

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_mem_stage (
	rv_stage_if.mem                 stage,
	input  logic [`RV_XLEN-1:0]     alu_res,
	input  logic [`RV_XLEN-1:0]     mem_rdata,
	output logic                    mem_valid,
	output logic [`RV_XLEN-1:0]     mem_addr,
	output logic [`RV_XLEN-1:0]     mem_wdata,
	output logic [`RV_XLEN/8-1:0]   mem_wstrb,
	output logic [`RV_XLEN/8-1:0]   mem_rmask,
	output logic [`RV_XLEN-1:0]     rd_wdata
);
	import rv_core_pkg::*;

	logic                  is_load;
	logic                  is_store;
	logic [`RV_XLEN/8-1:0] size_mask;
	logic [`RV_XLEN-1:0]   load_ext;

	assign is_load  = (stage.op_class == cls_load);
	assign is_store = (stage.op_class == cls_store);

	// Byte lanes from the access size
	always_comb begin
		case (stage.funct3[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			2'b10:   size_mask = 4'b1111;
			default: size_mask = 4'b0000;
		endcase
	end

	assign mem_valid = is_load || is_store;
	assign mem_addr  = mem_valid ? alu_res : '0;
	assign mem_wdata = is_store ? stage.rs2_val : '0;
	assign mem_wstrb = is_store ? size_mask : '0;
	assign mem_rmask = is_load ? size_mask : '0;

	// funct3[2] selects zero extension
	always_comb begin
		case (stage.funct3)
			3'b000:  load_ext = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			3'b001:  load_ext = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			3'b100:  load_ext = {24'b0, mem_rdata[7:0]};
			3'b101:  load_ext = {16'b0, mem_rdata[15:0]};
			default: load_ext = mem_rdata;
		endcase
	end

	assign rd_wdata = is_load ? load_ext : alu_res;

endmodule

// File: source/rv_comb_core.sv
/* Top level of the single-cycle RV32I core with PC register,
   completion and trap logic */

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_comb_core (
	input  logic                  clk,
	input  logic                  arst_n,
	output logic [`RV_XLEN-1:0]   insn_addr,
	input  logic [`RV_XLEN-1:0]   insn,
	input  logic                  insn_valid,
	output logic                  insn_complete,
	output logic                  trap,
	output logic [`RV_REG_AW-1:0] rs1_addr,
	output logic [`RV_REG_AW-1:0] rs2_addr,
	output logic [`RV_REG_AW-1:0] rd_addr,
	output logic                  rs1_request,
	output logic                  rs2_request,
	output logic                  rd_request,
	input  logic [`RV_XLEN-1:0]   rs1_rdata,
	input  logic [`RV_XLEN-1:0]   rs2_rdata,
	output logic [`RV_XLEN-1:0]   rd_wdata,
	input  logic                  rs1_ready,
	input  logic                  rs2_ready,
	input  logic                  rd_ready,
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output logic [`RV_XLEN-1:0]   mem_addr,
	output logic [`RV_XLEN-1:0]   mem_wdata,
	output logic [`RV_XLEN/8-1:0] mem_wstrb,
	output logic [`RV_XLEN/8-1:0] mem_rmask,
	input  logic [`RV_XLEN-1:0]   mem_rdata
);

	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] pc_next;
	logic [`RV_XLEN-1:0] alu_res;
	logic                illegal;

	rv_stage_if stage_bus ();

	rv_decode u_decode (
		.insn        (insn),
		.insn_valid  (insn_valid),
		.insn_addr   (pc),
		.rs1_rdata   (rs1_rdata),
		.rs2_rdata   (rs2_rdata),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rd_addr     (rd_addr),
		.rs1_request (rs1_request),
		.rs2_request (rs2_request),
		.rd_request  (rd_request),
		.illegal     (illegal),
		.stage       (stage_bus.decode)
	);

	rv_execute u_execute (
		.stage   (stage_bus.exec),
		.alu_res (alu_res),
		.pc_next (pc_next)
	);

	rv_mem_stage u_mem_stage (
		.stage     (stage_bus.mem),
		.alu_res   (alu_res),
		.mem_rdata (mem_rdata),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_rmask (mem_rmask),
		.rd_wdata  (rd_wdata)
	);

	// Every raised request needs its ready
	assign insn_complete = insn_valid &&
		(!rs1_request || rs1_ready) && (!rs2_request || rs2_ready) &&
		(!rd_request || rd_ready) && (!mem_valid || mem_ready);

	assign trap = insn_valid && illegal;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `RV_PROGADDR_RESET;
		end else if (insn_complete && !trap) begin
			pc <= pc_next; // Trap or stall holds the PC
		end
	end

	assign insn_addr = pc;

endmodule

// File: verif/rv_comb_core_assert.sv
/* Bound checker with reference RV32I rules and the concurrent assertions
   that compare the core against them */

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_comb_core_assert (
	input logic                  clk,
	input logic                  arst_n,
	input logic [`RV_XLEN-1:0]   insn_addr,
	input logic [`RV_XLEN-1:0]   insn,
	input logic                  insn_valid,
	input logic                  insn_complete,
	input logic                  trap,
	input logic [`RV_REG_AW-1:0] rs1_addr,
	input logic [`RV_REG_AW-1:0] rs2_addr,
	input logic [`RV_REG_AW-1:0] rd_addr,
	input logic                  rs1_request,
	input logic                  rs2_request,
	input logic                  rd_request,
	input logic                  rs1_ready,
	input logic                  rs2_ready,
	input logic                  rd_ready,
	input logic [`RV_XLEN-1:0]   rs1_rdata,
	input logic [`RV_XLEN-1:0]   rs2_rdata,
	input logic [`RV_XLEN-1:0]   rd_wdata,
	input logic                  mem_valid,
	input logic                  mem_ready,
	input logic [`RV_XLEN-1:0]   mem_addr,
	input logic [`RV_XLEN-1:0]   mem_wdata,
	input logic [`RV_XLEN/8-1:0] mem_wstrb,
	input logic [`RV_XLEN/8-1:0] mem_rmask,
	input logic [`RV_XLEN-1:0]   mem_rdata
);
	import rv_core_pkg::*;

	insn_u               w;
	logic [2:0]          f3;
	logic [6:0]          f7;
	logic                alt;
	logic                bad;
	logic                is_load;
	logic                is_store;
	logic                req_rs1;
	logic                req_rs2;
	logic                req_rd;
	logic                done;
	logic [3:0]          size;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_j;
	logic [`RV_XLEN-1:0] rs1v;
	logic [`RV_XLEN-1:0] rs2v;
	logic [`RV_XLEN-1:0] opb;
	logic [`RV_XLEN-1:0] pc4;
	logic [`RV_XLEN-1:0] exp_wd;
	logic [`RV_XLEN-1:0] exp_next;
	logic [`RV_XLEN-1:0] exp_addr;
	logic [`RV_XLEN-1:0] prev_next;
	int                  fail_count = 0;

	function automatic logic [31:0] alu_rule(logic [2:0] op, logic sub, logic [31:0] x,
		logic [31:0] y);
		case (op)
			3'b000:  return sub ? x - y : x + y;
			3'b001:  return x << y[4:0];
			3'b010:  return {31'b0, $signed(x) < $signed(y)};
			3'b011:  return {31'b0, x < y};
			3'b100:  return x ^ y;
			3'b101:  return sub ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'b110:  return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branch_rule(logic [2:0] op, logic [31:0] x, logic [31:0] y);
		case (op)
			3'b000:  return x == y;
			3'b001:  return x != y;
			3'b100:  return $signed(x) < $signed(y);
			3'b101:  return $signed(x) >= $signed(y);
			3'b110:  return x < y;
			default: return x >= y;
		endcase
	endfunction

	function automatic logic [31:0] load_rule(logic [2:0] op, logic [31:0] d);
		case (op)
			3'b000:  return {{24{d[7]}}, d[7:0]};
			3'b001:  return {{16{d[15]}}, d[15:0]};
			3'b100:  return {24'b0, d[7:0]};
			3'b101:  return {16'b0, d[15:0]};
			default: return d;
		endcase
	endfunction

	assign w        = insn;
	assign f3       = w.r.funct3;
	assign f7       = w.r.funct7;
	assign imm_i    = {{20{insn[31]}}, w.i.imm12};
	assign imm_s    = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b    = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j    = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	assign rs1v     = (w.r.rs1 == 5'd0) ? '0 : rs1_rdata;
	assign rs2v     = (w.r.rs2 == 5'd0) ? '0 : rs2_rdata;
	assign opb      = (w.r.opcode == opc_op) ? rs2v : imm_i;
	assign alt      = insn[30] && ((w.r.opcode == opc_op) || (f3 == 3'b101));
	assign pc4      = insn_addr + 32'd4;
	assign is_load  = (w.r.opcode == opc_load);
	assign is_store = (w.r.opcode == opc_store);
	assign exp_addr = rs1v + (is_store ? imm_s : imm_i);
	assign size     = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;

	// Registers the format reads or writes, x0 never
	assign req_rs1 = (w.r.rs1 != 5'd0) && !(w.r.opcode inside {opc_lui, opc_auipc, opc_jal});
	assign req_rs2 = (w.r.rs2 != 5'd0) && (w.r.opcode inside {opc_branch, opc_store, opc_op});
	assign req_rd  = (w.r.rd != 5'd0) && !(w.r.opcode inside {opc_branch, opc_store});
	assign done    = !(req_rs1 && !rs1_ready) && !(req_rs2 && !rs2_ready) &&
		!(req_rd && !rd_ready) && !((is_load || is_store) && !mem_ready);

	always_comb begin
		exp_wd   = alu_rule(f3, alt, rs1v, opb);
		exp_next = pc4;
		bad      = 1'b0;
		case (w.r.opcode)
			opc_lui:   exp_wd = {insn[31:12], 12'b0};
			opc_auipc: exp_wd = insn_addr + {insn[31:12], 12'b0};
			opc_jal: begin
				exp_wd   = pc4; // Link
				exp_next = (insn_addr + imm_j) & `RV_ALIGN_MASK;
			end
			opc_jalr: begin
				exp_wd   = pc4;
				exp_next = (rs1v + imm_i) & `RV_ALIGN_MASK;
				bad      = (f3 != 3'b000);
			end
			opc_branch: begin
				exp_next = branch_rule(f3, rs1v, rs2v) ? insn_addr + imm_b : pc4;
				bad      = (f3[2:1] == 2'b01);
			end
			opc_load: begin
				exp_wd = load_rule(f3, mem_rdata);
				bad    = (f3 == 3'b011) || (f3 > 3'b101);
			end
			opc_store: bad = (f3 > 3'b010);
			opc_op_imm: bad = ((f3 == 3'b001) && (f7 != 7'd0)) ||
				((f3 == 3'b101) && (f7 != 7'd0) && (f7 != 7'h20));
			opc_op: bad = (f7 != 7'd0) &&
				!((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
			default: bad = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_next <= `RV_PROGADDR_RESET;
		end else begin
			prev_next <= exp_next; // Target of the word just sampled
		end
	end

	a_reset_pc: assert property (@(posedge clk)
		$rose(arst_n) |-> insn_addr == `RV_PROGADDR_RESET)
		else begin
			fail_count++;
			$error("FAILED reset_pc expected %h actual %h", `RV_PROGADDR_RESET,
				$sampled(insn_addr));
		end

	a_idle: assert property (@(posedge clk) disable iff (!arst_n) !insn_valid |->
		!(trap || insn_complete || mem_valid || rs1_request || rs2_request || rd_request))
		else begin
			fail_count++;
			$error("Trap, completion or a request raised while insn_valid is low");
		end

	a_trap: assert property (@(posedge clk) disable iff (!arst_n) insn_valid |-> trap == bad)
		else begin
			fail_count++;
			$error("FAILED trap expected %b actual %b", $sampled(bad), $sampled(trap));
		end

	a_request: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid && !bad |->
		{rs1_request, rs2_request, rd_request, mem_valid} ==
		{req_rs1, req_rs2, req_rd, is_load || is_store})
		else begin
			fail_count++;
			$error("FAILED request expected %b actual %b",
				$sampled({req_rs1, req_rs2, req_rd, is_load || is_store}),
				$sampled({rs1_request, rs2_request, rd_request, mem_valid}));
		end

	a_reg_addr: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid && !bad |-> (!req_rs1 || rs1_addr == w.r.rs1) &&
		(!req_rs2 || rs2_addr == w.r.rs2) && (!req_rd || rd_addr == w.r.rd))
		else begin
			fail_count++;
			$error("FAILED reg_addr expected %h actual %h",
				$sampled({w.r.rs1, w.r.rs2, w.r.rd}), $sampled({rs1_addr, rs2_addr, rd_addr}));
		end

	a_wdata: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid && !bad && !is_store && (w.r.opcode != opc_branch) |-> rd_wdata == exp_wd)
		else begin
			fail_count++;
			$error("FAILED rd_wdata expected %h actual %h", $sampled(exp_wd), $sampled(rd_wdata));
		end

	a_mem_addr: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid && !bad && (is_load || is_store) |-> mem_valid && mem_addr == exp_addr)
		else begin
			fail_count++;
			$error("FAILED mem_addr expected %h actual %h", $sampled(exp_addr), $sampled(mem_addr));
		end

	a_store_data: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid && !bad && is_store |-> mem_wdata == rs2v)
		else begin
			fail_count++;
			$error("FAILED store_data expected %h actual %h", $sampled(rs2v),
				$sampled(mem_wdata));
		end

	a_mem_mask: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid && !bad && (is_load || is_store) |->
		(is_load ? mem_rmask : mem_wstrb) == size)
		else begin
			fail_count++;
			$error("FAILED mem_mask expected %b actual %b", $sampled(size),
				$sampled(is_load ? mem_rmask : mem_wstrb));
		end

	a_complete: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid && !bad |-> insn_complete == done)
		else begin
			fail_count++;
			$error("FAILED complete expected %b actual %b", $sampled(done),
				$sampled(insn_complete));
		end

	a_next_pc: assert property (@(posedge clk) disable iff (!arst_n)
		insn_complete && !trap |=> insn_addr == prev_next)
		else begin
			fail_count++;
			$error("FAILED next_pc expected %h actual %h", $sampled(prev_next),
				$sampled(insn_addr));
		end

	a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!(insn_complete && !trap) |=> $stable(insn_addr))
		else begin
			fail_count++;
			$error("PC moved without a completed legal instruction");
		end

endmodule

bind rv_comb_core rv_comb_core_assert u_chk (.*);

// File: verif/rv_comb_core_tb.sv
/* Testbench for the RV32I combinational core with register and memory
   responders, directed and random instructions, per-test lines and timeout */

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_comb_core_tb;
	import rv_core_pkg::*;

	localparam int n_random    = 200;
	localparam int test_cycles = 45 + 3 * n_random;
	localparam int cycle_limit = 2 * test_cycles;

	logic                  clk;
	logic                  arst_n;
	logic [`RV_XLEN-1:0]   insn_addr;
	logic [`RV_XLEN-1:0]   insn;
	logic                  insn_valid;
	logic                  insn_complete;
	logic                  trap;
	logic [`RV_REG_AW-1:0] rs1_addr;
	logic [`RV_REG_AW-1:0] rs2_addr;
	logic [`RV_REG_AW-1:0] rd_addr;
	logic                  rs1_request;
	logic                  rs2_request;
	logic                  rd_request;
	logic [`RV_XLEN-1:0]   rs1_rdata;
	logic [`RV_XLEN-1:0]   rs2_rdata;
	logic [`RV_XLEN-1:0]   rd_wdata;
	logic                  rs1_ready;
	logic                  rs2_ready;
	logic                  rd_ready;
	logic                  mem_valid;
	logic                  mem_ready;
	logic [`RV_XLEN-1:0]   mem_addr;
	logic [`RV_XLEN-1:0]   mem_wdata;
	logic [`RV_XLEN/8-1:0] mem_wstrb;
	logic [`RV_XLEN/8-1:0] mem_rmask;
	logic [`RV_XLEN-1:0]   mem_rdata;
	int                    seed = 10;
	int                    cycles = 0;
	int                    fail_mark = 0;

	rv_comb_core uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout, run stopped after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Legal OP, OP-IMM, LUI or AUIPC word
	function automatic logic [31:0] alu_word();
		logic [31:0] r;
		logic [2:0]  f3;
		logic        alt;
		r   = $random(seed);
		f3  = r[14:12];
		alt = r[30];
		case (r[1:0])
			2'd0: return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, r[24:15], f3,
				r[11:7], opc_op};
			2'd1: begin
				if (f3 == 3'd1 || f3 == 3'd5) begin
					return {(alt && f3 == 3'd5) ? 7'h20 : 7'h00, r[24:15], f3, r[11:7], opc_op_imm};
				end
				return {r[31:15], f3, r[11:7], opc_op_imm};
			end
			2'd2: return {r[31:7], opc_lui};
			default: return {r[31:7], opc_auipc};
		endcase
	endfunction

	// Branch, JAL or JALR word
	function automatic logic [31:0] ctrl_word();
		logic [31:0] r;
		logic [2:0]  f3;
		r  = $random(seed);
		f3 = r[14:12];
		if (f3[2:1] == 2'b01) f3[1] = 1'b0; // Skip the unused 010 and 011
		case (r[1:0])
			2'd0, 2'd1: return {r[31:15], f3, r[11:7], opc_branch};
			2'd2: return {r[31:7], opc_jal};
			default: return {r[31:15], 3'b000, r[11:7], opc_jalr};
		endcase
	endfunction

	// Load of any legal size or store of any legal size
	function automatic logic [31:0] mem_word();
		logic [31:0] r;
		logic [2:0]  f3;
		r  = $random(seed);
		f3 = r[14:12];
		if (r[0]) begin
			if (f3 == 3'd3) f3 = 3'd2;
			if (f3 > 3'd5) f3 = f3 - 3'd2;
			return {r[31:15], f3, r[11:7], opc_load};
		end
		f3 = {1'b0, r[13:12]};
		if (f3 == 3'd3) f3 = 3'd2;
		return {r[31:15], f3, r[11:7], opc_store};
	endfunction

	// One instruction, with all readies low for the first stall cycles
	task automatic run_insn(input logic [31:0] word, input int stall);
		@(negedge clk);
		insn       = word;
		insn_valid = 1'b1;
		rs1_rdata  = $random(seed);
		// Equal operands now and then
		rs2_rdata  = ($random(seed) % 4 == 0) ? rs1_rdata : $random(seed);
		mem_rdata  = $random(seed);
		if (stall > 0) begin
			{rs1_ready, rs2_ready, rd_ready, mem_ready} = 4'b0000;
			repeat (stall) @(negedge clk);
			{rs1_ready, rs2_ready, rd_ready, mem_ready} = 4'b1111;
		end
		@(posedge clk);
	endtask

	task automatic end_test(input string name);
		@(negedge clk);
		$display("test %s done, %0d assertion failures", name, uut.u_chk.fail_count - fail_mark);
		fail_mark = uut.u_chk.fail_count;
	endtask

	initial begin
		arst_n     = 1'b0;
		insn       = '0;
		insn_valid = 1'b0;
		rs1_rdata  = '0;
		rs2_rdata  = '0;
		mem_rdata  = '0;
		rs1_ready  = 1'b1;
		rs2_ready  = 1'b1;
		rd_ready   = 1'b1;
		mem_ready  = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		repeat (3) @(negedge clk);
		end_test("reset_idle");
		repeat (n_random) run_insn(alu_word(), 0);
		end_test("alu");
		repeat (n_random) run_insn(ctrl_word(), 0);
		end_test("control_flow");
		repeat (n_random) run_insn(mem_word(), 0);
		end_test("load_store");
		repeat (3) begin
			run_insn(mem_word(), 2);
			run_insn(alu_word() | 32'h0000_0080, 2); // rd never x0
		end
		end_test("backpressure");
		run_insn(32'h0000_2063, 1); // BRANCH with funct3 010
		run_insn(32'hFFFF_FFFF, 1);
		end_test("illegal");
		insn_valid = 1'b0;
		@(negedge clk);
		$display("tests done: 6 tests, %0d assertion failures", uut.u_chk.fail_count);
		if (uut.u_chk.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: rv_comb_core.f
+incdir+source
source/rv_core_pkg.sv
source/rv_stage_if.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_mem_stage.sv
source/rv_comb_core.sv
verif/rv_comb_core_assert.sv
verif/rv_comb_core_tb.sv

// File: Makefile
TOP := rv_comb_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rv_comb_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv_comb_core.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
